// File: hw/udp_stream_defs.svh
// Sizes and defaults; UDP_PAYLOAD_SAMPLES must be a multiple of 4 and at least 8
`ifndef UDP_STREAM_DEFS_SVH
`define UDP_STREAM_DEFS_SVH

//////////////////////////////
// Frame geometry
`define UDP_PAYLOAD_SAMPLES 64
`define UDP_SAMPLE_BITS     16
`define UDP_BEAT_BYTES      8
`define UDP_HDR_BYTES       42                       // Eth 14 + IP 20 + UDP 8
`define UDP_BUF_BEATS       (`UDP_PAYLOAD_SAMPLES / 4)
`define UDP_FRAME_BEATS     (`UDP_BUF_BEATS + 6)
`define UDP_CSUM_CYCLES     11

//////////////////////////////
// Register byte offsets
`define REG_SENT_COUNT 6'h04
`define REG_RECV_COUNT 6'h08
`define REG_DST_MAC_LO 6'h0C
`define REG_DST_MAC_HI 6'h10
`define REG_SRC_IP     6'h14
`define REG_DST_IP     6'h18
`define REG_SRC_PORT   6'h1C
`define REG_DST_PORT   6'h20
`define REG_DROP_COUNT 6'h24

//////////////////////////////
// Reset defaults
`define DEF_DST_MAC  48'hFFFF_FFFF_FFFF             // Broadcast
`define DEF_SRC_MAC  48'h001A_2B3C_4D5E
`define DEF_SRC_IP   32'hC0A8_0463                  // 192.168.4.99
`define DEF_DST_IP   32'hC0A8_0401                  // 192.168.4.1
`define DEF_PORT     16'd60133
`define DEF_TTL      8'd255
`define DEF_IP_ID    16'h0001
`define DEF_IP_FLAGS 16'h4000                       // Don't fragment

`endif

// File: hw/udp_stream_pkg.sv
// Shared types; in a beat, byte 0 (bits 7:0) is the first byte on the wire
`default_nettype none

`include "udp_stream_defs.svh"

package udp_stream_pkg;

    typedef logic [`UDP_BEAT_BYTES*8-1:0]       beat_t;
    typedef logic [47:0]                        mac_t;
    typedef logic [31:0]                        ipv4_t;
    typedef logic [15:0]                        port_t;
    typedef logic [31:0]                        count_t;
    typedef logic [5:0]                         reg_addr_t;
    typedef logic [31:0]                        reg_data_t;
    typedef logic [$clog2(`UDP_BUF_BEATS)-1:0]  buf_addr_t;    // Beat index inside one bank
    typedef logic [7:0]                         frame_idx_t;   // Output beat index

    // Packet sequencer states
    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_WAIT_HDR,
        SEQ_HEADER,
        SEQ_PAYLOAD
    } seq_state_t;

endpackage

`default_nettype wire

// File: hw/control_regs.sv
// Counters are read-only; the MAC low word only takes effect with the following MAC high write
`timescale 1ns/1ps
`default_nettype none

`include "udp_stream_defs.svh"

module control_regs
    import udp_stream_pkg::*;
(
    input  wire       m00_axis_aclk,
    input  wire       s00_axi_aresetn,
    input  wire       cfg_wr,
    input  wire       cfg_rd,
    input  wire reg_addr_t cfg_addr,
    input  wire reg_data_t cfg_wdata,
    output reg_data_t cfg_rdata,
    output logic      cfg_rvalid,
    output mac_t      dst_mac,
    output ipv4_t     src_ip,
    output ipv4_t     dst_ip,
    output port_t     src_port,
    output port_t     dst_port,
    input  wire count_t sent_count,
    input  wire count_t recv_count,
    input  wire count_t drop_count
);

    reg_data_t mac_lo_stage;     // Low four MAC bytes, waiting for the high half
    reg_data_t rd_mux;

    // Write decode
    always_ff @(posedge m00_axis_aclk or negedge s00_axi_aresetn) begin
        if (!s00_axi_aresetn) begin
            dst_mac      <= `DEF_DST_MAC;
            src_ip       <= `DEF_SRC_IP;
            dst_ip       <= `DEF_DST_IP;
            src_port     <= `DEF_PORT;
            dst_port     <= `DEF_PORT;
            mac_lo_stage <= '0;
        end else if (cfg_wr) begin
            case (cfg_addr)
                `REG_DST_MAC_LO: mac_lo_stage <= cfg_wdata;
                `REG_DST_MAC_HI: dst_mac <= {cfg_wdata[15:0], mac_lo_stage};  // Whole MAC at once
                `REG_SRC_IP:     src_ip <= cfg_wdata;
                `REG_DST_IP:     dst_ip <= cfg_wdata;
                `REG_SRC_PORT:   src_port <= cfg_wdata[15:0];
                `REG_DST_PORT:   dst_port <= cfg_wdata[15:0];
                default: ;
            endcase
        end
    end

    // Read mux, unmapped offsets give zero
    always_comb begin
        case (cfg_addr)
            `REG_SENT_COUNT: rd_mux = sent_count;
            `REG_RECV_COUNT: rd_mux = recv_count;
            `REG_DST_MAC_LO: rd_mux = dst_mac[31:0];
            `REG_DST_MAC_HI: rd_mux = {16'h0000, dst_mac[47:32]};
            `REG_SRC_IP:     rd_mux = src_ip;
            `REG_DST_IP:     rd_mux = dst_ip;
            `REG_SRC_PORT:   rd_mux = {16'h0000, src_port};
            `REG_DST_PORT:   rd_mux = {16'h0000, dst_port};
            `REG_DROP_COUNT: rd_mux = drop_count;
            default:         rd_mux = '0;
        endcase
    end

    always_ff @(posedge m00_axis_aclk or negedge s00_axi_aresetn) begin
        if (!s00_axi_aresetn) cfg_rvalid <= 1'b0;
        else                  cfg_rvalid <= cfg_rd;     // Response one cycle after the strobe
    end

    always_ff @(posedge m00_axis_aclk) begin
        if (cfg_rd) cfg_rdata <= rd_mux;
    end

    // Counters from the other blocks never skip a value
    a_count_step: assert property (@(posedge m00_axis_aclk) disable iff (!s00_axi_aresetn)
        (count_t'(sent_count - $past(sent_count)) <= 32'd1)
            && (count_t'(recv_count - $past(recv_count)) <= 32'd1)
            && (count_t'(drop_count - $past(drop_count)) <= 32'd1));

endmodule

`default_nettype wire

// File: hw/sample_pingpong_buffer.sv
// No input back-pressure; beats arriving while the filling bank is still occupied are dropped
`timescale 1ns/1ps
`default_nettype none

`include "udp_stream_defs.svh"

module sample_pingpong_buffer
    import udp_stream_pkg::*;
(
    input  wire        m00_axis_aclk,
    input  wire        s00_axi_aresetn,
    input  wire        s01_axis_tvalid,
    input  wire beat_t s01_axis_tdata,
    output logic       frame_ready,
    input  wire        frame_read,
    output beat_t      frame_data,
    output count_t     recv_count,
    output count_t     drop_count
);

    localparam buf_addr_t LAST_ADDR = buf_addr_t'(`UDP_BUF_BEATS - 1);

    beat_t     mem [2][`UDP_BUF_BEATS];
    logic      wr_bank;
    logic      rd_bank;                 // Oldest ready bank
    buf_addr_t wr_ptr;
    buf_addr_t rd_ptr;
    logic [1:0] bank_ready;             // Full and waiting, or being read
    logic      wr_en;

    assign wr_en       = s01_axis_tvalid && !bank_ready[wr_bank];
    assign frame_ready = bank_ready[rd_bank];

    //////////////////////////////
    // Bank control and counters
    always_ff @(posedge m00_axis_aclk or negedge s00_axi_aresetn) begin
        if (!s00_axi_aresetn) begin
            wr_bank    <= 1'b0;
            rd_bank    <= 1'b0;
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            bank_ready <= 2'b00;
            recv_count <= '0;
            drop_count <= '0;
        end else begin
            if (s01_axis_tvalid) recv_count <= recv_count + 1'b1;
            if (s01_axis_tvalid && !wr_en) drop_count <= drop_count + 1'b1;
            if (wr_en) begin
                wr_ptr <= (wr_ptr == LAST_ADDR) ? '0 : wr_ptr + 1'b1;
                if (wr_ptr == LAST_ADDR) begin
                    bank_ready[wr_bank] <= 1'b1;    // Hand off and swap banks
                    wr_bank             <= !wr_bank;
                end
            end
            if (frame_read) begin
                rd_ptr <= (rd_ptr == LAST_ADDR) ? '0 : rd_ptr + 1'b1;
                if (rd_ptr == LAST_ADDR) begin
                    bank_ready[rd_bank] <= 1'b0;    // Last beat out, bank is free
                    rd_bank             <= !rd_bank;
                end
            end
        end
    end

    //////////////////////////////
    // Storage with registered read port
    always_ff @(posedge m00_axis_aclk) begin
        if (wr_en) mem[wr_bank][wr_ptr] <= s01_axis_tdata;
        if (frame_read) frame_data <= mem[rd_bank][rd_ptr];
    end

    a_read_when_ready: assert property (@(posedge m00_axis_aclk) disable iff (!s00_axi_aresetn)
        frame_read |-> frame_ready);

endmodule

`default_nettype wire

// File: hw/header_builder.sv
// Source MAC is fixed; only IPv4/UDP with fixed payload length and a zero UDP checksum
`timescale 1ns/1ps
`default_nettype none

`include "udp_stream_defs.svh"

module header_builder
    import udp_stream_pkg::*;
(
    input  wire        m00_axis_aclk,
    input  wire        s00_axi_aresetn,
    input  wire mac_t  dst_mac,
    input  wire ipv4_t src_ip,
    input  wire ipv4_t dst_ip,
    input  wire port_t src_port,
    input  wire port_t dst_port,
    input  wire        hdr_load,
    output logic       hdr_ready,
    input  wire frame_idx_t hdr_index,
    output beat_t      hdr_word
);

    localparam int    PAY_BYTES = `UDP_PAYLOAD_SAMPLES * `UDP_SAMPLE_BITS / 8;
    localparam port_t IP_LEN    = port_t'(`UDP_HDR_BYTES - 14 + PAY_BYTES);
    localparam port_t UDP_LEN   = port_t'(`UDP_HDR_BYTES - 34 + PAY_BYTES);
    localparam int    HDR_BITS  = `UDP_HDR_BYTES * 8;

    mac_t        dst_mac_q;
    ipv4_t       src_ip_q, dst_ip_q;
    port_t       src_port_q, dst_port_q;
    logic [19:0] csum_acc;
    logic [16:0] fold_1;
    logic [15:0] csum, half_word;
    logic [3:0]  csum_cnt;
    logic        csum_busy;
    logic [HDR_BITS-1:0] hdr_bytes;     // Byte 0 in the top bits

    // IP header halfwords, checksum slot counted as zero
    always_comb begin
        case (csum_cnt)
            4'd0:    half_word = 16'h4500;
            4'd1:    half_word = IP_LEN;
            4'd2:    half_word = `DEF_IP_ID;
            4'd3:    half_word = `DEF_IP_FLAGS;
            4'd4:    half_word = {`DEF_TTL, 8'h11};       // Protocol UDP
            4'd6:    half_word = src_ip_q[31:16];
            4'd7:    half_word = src_ip_q[15:0];
            4'd8:    half_word = dst_ip_q[31:16];
            4'd9:    half_word = dst_ip_q[15:0];
            default: half_word = 16'h0000;
        endcase
    end

    always_ff @(posedge m00_axis_aclk or negedge s00_axi_aresetn) begin
        if (!s00_axi_aresetn) begin
            csum_busy <= 1'b0;
            hdr_ready <= 1'b0;
            csum_cnt  <= '0;
        end else if (hdr_load) begin
            csum_busy <= 1'b1;
            hdr_ready <= 1'b0;
            csum_cnt  <= '0;
        end else if (csum_busy) begin
            csum_cnt <= csum_cnt + 1'b1;
            if (csum_cnt == 4'(`UDP_CSUM_CYCLES - 2)) begin   // Last halfword this cycle
                csum_busy <= 1'b0;
                hdr_ready <= 1'b1;
            end
        end
    end

    // Snapshot and accumulator
    always_ff @(posedge m00_axis_aclk) begin
        if (hdr_load) begin
            dst_mac_q  <= dst_mac;
            src_ip_q   <= src_ip;
            dst_ip_q   <= dst_ip;
            src_port_q <= src_port;
            dst_port_q <= dst_port;
            csum_acc   <= '0;
        end else if (csum_busy) begin
            csum_acc <= csum_acc + 20'(half_word);
        end
    end

    assign fold_1 = 17'(csum_acc[15:0]) + 17'(csum_acc[19:16]);
    assign csum   = ~(fold_1[15:0] + 16'(fold_1[16]));

    assign hdr_bytes = {dst_mac_q, `DEF_SRC_MAC, 16'h0800,
                        16'h4500, IP_LEN, `DEF_IP_ID, `DEF_IP_FLAGS, `DEF_TTL, 8'h11, csum,
                        src_ip_q, dst_ip_q,
                        src_port_q, dst_port_q, UDP_LEN, 16'h0000};

    // Beat lookup, bytes past the header read as zero
    always_comb begin
        int b;
        hdr_word = '0;
        for (int j = 0; j < `UDP_BEAT_BYTES; j++) begin
            b = `UDP_BEAT_BYTES * int'(hdr_index) + j;
            if (b < `UDP_HDR_BYTES) hdr_word[8*j +: 8] = hdr_bytes[HDR_BITS - 8 - 8*b +: 8];
        end
    end

    a_index_range: assert property (@(posedge m00_axis_aclk) disable iff (!s00_axi_aresetn)
        hdr_index != '0 |-> hdr_ready && hdr_index < 6);

endmodule

`default_nettype wire

// File: hw/packet_sequencer.sv
// One frame at a time; tdata is not cleared between beats and is only meaningful with tvalid
`timescale 1ns/1ps
`default_nettype none

`include "udp_stream_defs.svh"

module packet_sequencer
    import udp_stream_pkg::*;
(
    input  wire        m00_axis_aclk,
    input  wire        s00_axi_aresetn,
    input  wire        frame_ready,
    output logic       frame_read,
    input  wire beat_t frame_data,
    output logic       hdr_load,
    input  wire        hdr_ready,
    output frame_idx_t hdr_index,
    input  wire beat_t hdr_word,
    output logic       m00_axis_tvalid,
    output beat_t      m00_axis_tdata,
    output logic [`UDP_BEAT_BYTES-1:0] m00_axis_tkeep,
    output logic       m00_axis_tlast,
    input  wire        m00_axis_tready,
    output count_t     sent_count
);

    localparam frame_idx_t LAST_BEAT = frame_idx_t'(`UDP_FRAME_BEATS - 1);
    localparam frame_idx_t JOIN_BEAT = frame_idx_t'(5);    // Header tail plus first samples
    localparam frame_idx_t BUF_BEATS = frame_idx_t'(`UDP_BUF_BEATS);

    seq_state_t  state;
    frame_idx_t  idx;           // Next output beat
    frame_idx_t  rd_cnt;        // Buffer reads issued this frame
    logic        fd_full;       // frame_data holds an unused beat
    logic        can_load, load_beat, consume, sending;
    logic [15:0] prev_hi;       // Top two bytes of the previous buffer beat
    beat_t       next_beat;

    assign sending    = (state == SEQ_HEADER) || (state == SEQ_PAYLOAD);
    assign can_load   = !m00_axis_tvalid || m00_axis_tready;
    assign hdr_load   = (state == SEQ_IDLE) && frame_ready;
    assign hdr_index  = (state == SEQ_HEADER) ? idx : '0;
    assign frame_read = sending && (rd_cnt < BUF_BEATS) && (!fd_full || consume);

    //////////////////////////////
    // Next output beat
    always_comb begin
        load_beat = 1'b0;
        consume   = 1'b0;
        next_beat = hdr_word;
        if (can_load && state == SEQ_HEADER && idx < JOIN_BEAT) begin
            load_beat = 1'b1;
        end else if (can_load && sending && idx < LAST_BEAT) begin
            load_beat = fd_full;                       // Wait for buffer data
            consume   = fd_full;
            next_beat = {frame_data[47:0], (state == SEQ_HEADER) ? hdr_word[15:0] : prev_hi};
        end else if (can_load && state == SEQ_PAYLOAD) begin
            load_beat = 1'b1;                          // Closing two bytes
            next_beat = {48'h0, prev_hi};
        end
    end

    //////////////////////////////
    // FSM and output control
    always_ff @(posedge m00_axis_aclk or negedge s00_axi_aresetn) begin
        if (!s00_axi_aresetn) begin
            state           <= SEQ_IDLE;
            idx             <= '0;
            rd_cnt          <= '0;
            fd_full         <= 1'b0;
            m00_axis_tvalid <= 1'b0;
            m00_axis_tkeep  <= '1;
            m00_axis_tlast  <= 1'b0;
            sent_count      <= '0;
        end else begin
            case (state)
                SEQ_IDLE: begin
                    if (frame_ready) begin
                        state  <= SEQ_WAIT_HDR;
                        rd_cnt <= '0;
                    end
                end
                SEQ_WAIT_HDR: begin
                    if (hdr_ready) begin
                        state <= SEQ_HEADER;
                        idx   <= '0;
                    end
                end
                default: ;
            endcase
            if (load_beat) begin
                idx            <= idx + 1'b1;
                m00_axis_tkeep <= (idx == LAST_BEAT) ? 8'h03 : 8'hFF;
                m00_axis_tlast <= (idx == LAST_BEAT);
                if (idx == JOIN_BEAT) state <= SEQ_PAYLOAD;
                if (idx == LAST_BEAT) state <= SEQ_IDLE;
            end
            if (frame_read) rd_cnt <= rd_cnt + 1'b1;
            fd_full <= frame_read || (fd_full && !consume);
            if (load_beat)            m00_axis_tvalid <= 1'b1;
            else if (m00_axis_tready) m00_axis_tvalid <= 1'b0;
            if (m00_axis_tvalid && m00_axis_tready && m00_axis_tlast) begin
                sent_count <= sent_count + 1'b1;
            end
        end
    end

    always_ff @(posedge m00_axis_aclk) begin
        if (load_beat) m00_axis_tdata <= next_beat;
        if (consume)   prev_hi <= frame_data[63:48];
    end

    a_hold_stall: assert property (@(posedge m00_axis_aclk) disable iff (!s00_axi_aresetn)
        m00_axis_tvalid && !m00_axis_tready |=> m00_axis_tvalid && $stable(m00_axis_tdata)
            && $stable(m00_axis_tkeep) && $stable(m00_axis_tlast));

endmodule

`default_nettype wire

// File: hw/adc_udp_top.sv
// Single clock domain; the sample input has no tready and must not outrun the output by more than two banks
`timescale 1ns/1ps
`default_nettype none

`include "udp_stream_defs.svh"

module adc_udp_top
    import udp_stream_pkg::*;
(
    input  wire        m00_axis_aclk,
    input  wire        s00_axi_aresetn,
    input  wire        s01_axis_tvalid,
    input  wire beat_t s01_axis_tdata,
    output logic       m00_axis_tvalid,
    output beat_t      m00_axis_tdata,
    output logic [`UDP_BEAT_BYTES-1:0] m00_axis_tkeep,
    output logic       m00_axis_tlast,
    input  wire        m00_axis_tready,
    input  wire        cfg_wr,
    input  wire        cfg_rd,
    input  wire reg_addr_t cfg_addr,
    input  wire reg_data_t cfg_wdata,
    output reg_data_t  cfg_rdata,
    output logic       cfg_rvalid
);

    mac_t       dst_mac;
    ipv4_t      src_ip, dst_ip;
    port_t      src_port, dst_port;
    count_t     sent_count, recv_count, drop_count;
    logic       frame_ready, frame_read, hdr_load, hdr_ready;
    beat_t      frame_data, hdr_word;
    frame_idx_t hdr_index;

    control_regs u_regs (
        .m00_axis_aclk, .s00_axi_aresetn,
        .cfg_wr, .cfg_rd, .cfg_addr, .cfg_wdata, .cfg_rdata, .cfg_rvalid,
        .dst_mac, .src_ip, .dst_ip, .src_port, .dst_port,
        .sent_count, .recv_count, .drop_count
    );

    sample_pingpong_buffer u_buf (
        .m00_axis_aclk, .s00_axi_aresetn,
        .s01_axis_tvalid, .s01_axis_tdata,
        .frame_ready, .frame_read, .frame_data,
        .recv_count, .drop_count
    );

    header_builder u_hdr (
        .m00_axis_aclk, .s00_axi_aresetn,
        .dst_mac, .src_ip, .dst_ip, .src_port, .dst_port,
        .hdr_load, .hdr_ready, .hdr_index, .hdr_word
    );

    packet_sequencer u_seq (
        .m00_axis_aclk, .s00_axi_aresetn,
        .frame_ready, .frame_read, .frame_data,
        .hdr_load, .hdr_ready, .hdr_index, .hdr_word,
        .m00_axis_tvalid, .m00_axis_tdata, .m00_axis_tkeep, .m00_axis_tlast,
        .m00_axis_tready, .sent_count
    );

endmodule

`default_nettype wire

// File: tests/tb_adc_udp.sv
// Checks assume 8-byte beats and a sample count that fills whole banks; the sink sees one frame per bank
`timescale 1ns/1ps
`default_nettype none

`include "udp_stream_defs.svh"

module tb_adc_udp
    import udp_stream_pkg::*;
();

    localparam int BUF_BEATS       = `UDP_BUF_BEATS;
    localparam int LAST_BEAT       = `UDP_FRAME_BEATS - 1;
    localparam int PAY_BYTES       = `UDP_PAYLOAD_SAMPLES * 2;
    localparam int HDR_BYTES       = `UDP_HDR_BYTES;
    localparam int FRAME_BYTES     = HDR_BYTES + PAY_BYTES;
    localparam int TOTAL_FRAMES    = 8;
    localparam int WATCHDOG_CYCLES = TOTAL_FRAMES * 3 * `UDP_FRAME_BEATS * `UDP_BUF_BEATS + 2000;

    logic        m00_axis_aclk;
    logic        s00_axi_aresetn;
    logic        s01_axis_tvalid;
    beat_t       s01_axis_tdata;
    logic        m00_axis_tvalid;
    beat_t       m00_axis_tdata;
    logic [7:0]  m00_axis_tkeep;
    logic        m00_axis_tlast;
    logic        m00_axis_tready;
    logic        cfg_wr;
    logic        cfg_rd;
    reg_addr_t   cfg_addr;
    reg_data_t   cfg_wdata;
    reg_data_t   cfg_rdata;
    logic        cfg_rvalid;

    integer      seed = 76999;
    logic [31:0] rnd;
    int          errors, checks, tests_run;
    int          frames_seen, frames_queued, beats_driven, beat_idx;
    int          ready_mode;                  // 0 low, 1 high, 2 random
    logic [15:0] next_sample;
    logic [7:0]  rx_bytes[$];
    logic [7:0]  exp_payload[$];              // Stored sample bytes in wire order
    logic [7:0]  exp_hdr [HDR_BYTES];
    mac_t        cur_dst_mac;
    ipv4_t       cur_src_ip, cur_dst_ip;
    port_t       cur_src_port, cur_dst_port;
    logic        stalled;
    beat_t       held_data;

    adc_udp_top DUT (.*);

    initial begin
        m00_axis_aclk = 1'b0;
        forever #10 m00_axis_aclk = ~m00_axis_aclk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge m00_axis_aclk);
        $display("Watchdog expired after %0d cycles, frames stopped arriving", WATCHDOG_CYCLES);
        $display("TEST FAIL");
        $finish;
    end

    // Sink ready, changed just after each edge
    always @(posedge m00_axis_aclk) begin
        #2;
        rnd = $random(seed);
        case (ready_mode)
            0:       m00_axis_tready = 1'b0;
            1:       m00_axis_tready = 1'b1;
            default: m00_axis_tready = rnd[0];
        endcase
    end

    //////////////////////////////
    // Helpers
    task automatic step();
        @(posedge m00_axis_aclk);
        #2;
    endtask

    task automatic expect_equal(input string name, input logic [63:0] exp, input logic [63:0] act);
        checks++;
        assert (act === exp) else begin
            $display("Fail at %0t ns: %s expected %0h got %0h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic finish_test(input string name, input int err_mark);
        tests_run++;
        $display("Test %0d %-20s done, %0d errors", tests_run, name, errors - err_mark);
    endtask

    task automatic write_reg(input reg_addr_t addr, input reg_data_t data);
        step();
        cfg_wr    = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = data;
        step();
        cfg_wr = 1'b0;
    endtask

    // Response is due exactly one cycle after the strobe
    task automatic read_reg(input reg_addr_t addr, output reg_data_t data);
        step();
        cfg_rd   = 1'b1;
        cfg_addr = addr;
        step();
        cfg_rd = 1'b0;
        @(negedge m00_axis_aclk);
        expect_equal("cfg_rvalid", 64'(1), 64'(cfg_rvalid));
        data = cfg_rdata;
    endtask

    task automatic check_reg(input reg_addr_t addr, input reg_data_t exp, input string name);
        reg_data_t data;
        read_reg(addr, data);
        expect_equal(name, 64'(exp), 64'(data));
    endtask

    // Counting samples, lowest sample in the low bits; only n_store beats are expected out
    task automatic send_beats(input int n_drive, input int n_store);
        beat_t beat;
        int    i, j;
        for (i = 0; i < n_drive; i++) begin
            beat = {next_sample + 16'd3, next_sample + 16'd2, next_sample + 16'd1, next_sample};
            step();
            s01_axis_tvalid = 1'b1;
            s01_axis_tdata  = beat;
            if (i < n_store) begin
                for (j = 0; j < 8; j++) exp_payload.push_back(beat[8*j +: 8]);
            end
            next_sample = next_sample + 16'd4;
            beats_driven++;
        end
        step();
        s01_axis_tvalid = 1'b0;
    endtask

    task automatic send_frames(input int n);
        int k;
        for (k = 0; k < n; k++) begin
            while (frames_seen + 1 < frames_queued) @(posedge m00_axis_aclk);  // Keep a bank free
            send_beats(BUF_BEATS, BUF_BEATS);
            frames_queued++;
        end
    endtask

    task automatic wait_frames();
        while (frames_seen < frames_queued) @(posedge m00_axis_aclk);
    endtask

    //////////////////////////////
    // Reference frame model
    task automatic fill_expected_header();
        logic [15:0] ip_words [10];
        logic [31:0] sum;
        logic [47:0] src_mac;
        logic [15:0] udp_len;
        int          i;
        src_mac     = 48'h001A_2B3C_4D5E;
        udp_len     = 16'(8 + PAY_BYTES);
        ip_words[0] = 16'h4500;                   // IPv4, five-word header
        ip_words[1] = 16'(20 + 8 + PAY_BYTES);
        ip_words[2] = 16'h0001;
        ip_words[3] = 16'h4000;                   // Don't fragment
        ip_words[4] = 16'hFF11;                   // TTL 255, UDP
        ip_words[5] = 16'h0000;
        ip_words[6] = cur_src_ip[31:16];
        ip_words[7] = cur_src_ip[15:0];
        ip_words[8] = cur_dst_ip[31:16];
        ip_words[9] = cur_dst_ip[15:0];
        sum = 32'h0;
        for (i = 0; i < 10; i++) sum = sum + 32'(ip_words[i]);
        sum = 32'(sum[15:0]) + 32'(sum[31:16]);
        sum = 32'(sum[15:0]) + 32'(sum[31:16]);
        ip_words[5] = ~sum[15:0];
        for (i = 0; i < 6; i++) begin
            exp_hdr[i]     = cur_dst_mac[47 - 8*i -: 8];
            exp_hdr[6 + i] = src_mac[47 - 8*i -: 8];
        end
        exp_hdr[12] = 8'h08;
        exp_hdr[13] = 8'h00;
        for (i = 0; i < 10; i++) begin
            exp_hdr[14 + 2*i] = ip_words[i][15:8];
            exp_hdr[15 + 2*i] = ip_words[i][7:0];
        end
        exp_hdr[34] = cur_src_port[15:8];
        exp_hdr[35] = cur_src_port[7:0];
        exp_hdr[36] = cur_dst_port[15:8];
        exp_hdr[37] = cur_dst_port[7:0];
        exp_hdr[38] = udp_len[15:8];
        exp_hdr[39] = udp_len[7:0];
        exp_hdr[40] = 8'h00;                      // No UDP checksum
        exp_hdr[41] = 8'h00;
    endtask

    task automatic check_frame();
        logic [7:0]  exp_byte, act_byte, bad_exp, bad_act;
        logic [31:0] sum;
        int          i, bad_at;
        fill_expected_header();
        expect_equal("frame byte count", 64'(FRAME_BYTES), 64'(rx_bytes.size()));
        bad_at  = -1;
        bad_exp = 8'h00;
        bad_act = 8'h00;
        for (i = 0; i < FRAME_BYTES; i++) begin
            if (i < HDR_BYTES)             exp_byte = exp_hdr[i];
            else if (exp_payload.size() > 0) exp_byte = exp_payload.pop_front();
            else                           exp_byte = 8'hxx;
            act_byte = (i < rx_bytes.size()) ? rx_bytes[i] : 8'h00;
            if (act_byte !== exp_byte && bad_at < 0) begin
                bad_at  = i;
                bad_exp = exp_byte;
                bad_act = act_byte;
            end
        end
        expect_equal($sformatf("m00_axis_tdata byte %0d of frame %0d", bad_at, frames_seen),
                     64'(bad_exp), 64'(bad_act));
        sum = 32'h0;
        for (i = 14; i < 34; i += 2) sum = sum + {16'h0, rx_bytes[i], rx_bytes[i+1]};
        sum = 32'(sum[15:0]) + 32'(sum[31:16]);
        sum = 32'(sum[15:0]) + 32'(sum[31:16]);
        expect_equal("IPv4 header ones-complement sum", 64'hFFFF, 64'(sum[15:0]));
        rx_bytes.delete();
        frames_seen++;
    endtask

    task automatic collect_beat();
        int j;
        expect_equal("m00_axis_tkeep", (beat_idx == LAST_BEAT) ? 64'h03 : 64'hFF,
                     64'(m00_axis_tkeep));
        expect_equal("m00_axis_tlast", 64'(beat_idx == LAST_BEAT), 64'(m00_axis_tlast));
        for (j = 0; j < 8; j++) begin
            if (m00_axis_tkeep[j]) rx_bytes.push_back(m00_axis_tdata[8*j +: 8]);
        end
        if (m00_axis_tlast || beat_idx == LAST_BEAT) begin
            check_frame();
            beat_idx = 0;
        end else begin
            beat_idx++;
        end
    endtask

    // Output monitor, sampled mid-cycle
    always @(negedge m00_axis_aclk) begin
        if (s00_axi_aresetn) begin
            if (stalled) expect_equal("m00_axis_tdata", held_data, m00_axis_tdata);
            stalled   = m00_axis_tvalid && !m00_axis_tready;
            held_data = m00_axis_tdata;
            if (m00_axis_tvalid && m00_axis_tready) collect_beat();
        end
    end

    a_valid_held: assert property (@(posedge m00_axis_aclk) disable iff (!s00_axi_aresetn)
        m00_axis_tvalid && !m00_axis_tready |=> m00_axis_tvalid)
        else begin
            $display("Fail at %0t ns: m00_axis_tvalid expected 1 got 0", $time);
            errors++;
        end

    //////////////////////////////
    // Test sequence
    initial begin
        int mark;
        s00_axi_aresetn = 1'b0;
        s01_axis_tvalid = 1'b0;
        s01_axis_tdata  = '0;
        m00_axis_tready = 1'b0;
        cfg_wr          = 1'b0;
        cfg_rd          = 1'b0;
        cfg_addr        = '0;
        cfg_wdata       = '0;
        ready_mode      = 0;
        next_sample     = 16'h0000;
        stalled         = 1'b0;
        held_data       = '0;
        cur_dst_mac     = 48'hFFFF_FFFF_FFFF;
        cur_src_ip      = 32'hC0A8_0463;            // 192.168.4.99
        cur_dst_ip      = 32'hC0A8_0401;            // 192.168.4.1
        cur_src_port    = 16'd60133;
        cur_dst_port    = 16'd60133;
        repeat (8) @(posedge m00_axis_aclk);
        #2 s00_axi_aresetn = 1'b1;

        mark = errors;
        @(negedge m00_axis_aclk);
        expect_equal("m00_axis_tvalid", 64'(0), 64'(m00_axis_tvalid));
        expect_equal("m00_axis_tlast", 64'(0), 64'(m00_axis_tlast));
        check_reg(`REG_DST_MAC_LO, 32'hFFFF_FFFF, "dst_mac low");
        check_reg(`REG_DST_MAC_HI, 32'h0000_FFFF, "dst_mac high");
        check_reg(`REG_SRC_IP, cur_src_ip, "src_ip");
        check_reg(`REG_DST_IP, cur_dst_ip, "dst_ip");
        check_reg(`REG_SRC_PORT, 32'(cur_src_port), "src_port");
        check_reg(`REG_DST_PORT, 32'(cur_dst_port), "dst_port");
        check_reg(`REG_SENT_COUNT, 32'h0, "sent_count");
        check_reg(`REG_RECV_COUNT, 32'h0, "recv_count");
        check_reg(`REG_DROP_COUNT, 32'h0, "drop_count");
        finish_test("reset state", mark);

        mark = errors;
        cur_src_ip   = 32'h0A00_0005;
        cur_dst_ip   = 32'h0A00_0001;
        cur_src_port = 16'd5004;
        cur_dst_port = 16'd6006;
        write_reg(`REG_SRC_IP, cur_src_ip);
        write_reg(`REG_DST_IP, cur_dst_ip);
        write_reg(`REG_SRC_PORT, 32'(cur_src_port));
        write_reg(`REG_DST_PORT, 32'(cur_dst_port));
        check_reg(`REG_SRC_IP, cur_src_ip, "src_ip");
        check_reg(`REG_DST_IP, cur_dst_ip, "dst_ip");
        check_reg(`REG_SRC_PORT, 32'(cur_src_port), "src_port");
        check_reg(`REG_DST_PORT, 32'(cur_dst_port), "dst_port");
        write_reg(`REG_DST_MAC_LO, 32'h5E10_2030);
        check_reg(`REG_DST_MAC_LO, 32'hFFFF_FFFF, "dst_mac low before commit");
        write_reg(`REG_DST_MAC_HI, 32'h0000_0200);
        cur_dst_mac = 48'h0200_5E10_2030;
        check_reg(`REG_DST_MAC_LO, 32'h5E10_2030, "dst_mac low");
        check_reg(`REG_DST_MAC_HI, 32'h0000_0200, "dst_mac high");
        check_reg(6'h00, 32'h0, "unmapped 0x00");
        check_reg(6'h28, 32'h0, "unmapped 0x28");
        check_reg(6'h3C, 32'h0, "unmapped 0x3C");
        finish_test("registers", mark);

        mark = errors;
        ready_mode = 1;
        send_frames(2);
        wait_frames();
        finish_test("frame format", mark);

        mark = errors;
        ready_mode = 2;
        send_frames(4);
        wait_frames();
        finish_test("payload backpressure", mark);

        // Sink held off while three banks arrive, the third is lost
        mark = errors;
        check_reg(`REG_SENT_COUNT, 32'(frames_queued), "sent_count");
        check_reg(`REG_RECV_COUNT, 32'(beats_driven), "recv_count");
        ready_mode = 0;
        send_beats(3 * BUF_BEATS, 2 * BUF_BEATS);
        frames_queued += 2;
        check_reg(`REG_DROP_COUNT, 32'(BUF_BEATS), "drop_count");
        ready_mode = 2;
        wait_frames();
        check_reg(`REG_SENT_COUNT, 32'(frames_queued), "sent_count");
        check_reg(`REG_RECV_COUNT, 32'(beats_driven), "recv_count");
        finish_test("counters", mark);

        $display("Summary: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+hw
hw/udp_stream_pkg.sv
hw/control_regs.sv
hw/sample_pingpong_buffer.sv
hw/header_builder.sv
hw/packet_sequencer.sv
hw/adc_udp_top.sv
tests/tb_adc_udp.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --timing --assert
TOP       := tb_adc_udp
RTL_TOP   := adc_udp_top
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG) || ! grep -q "TEST PASS" $(LOG); then \
		echo "Simulation reported a failure, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
